// ==== icachePkg.sv ====
package icachePkg;

    // byte address, always physical
    typedef logic [31:0] addrT;

    typedef logic [31:0] wordT;

    // four words per line, word 0 sits in bits 31:0
    typedef logic [127:0] lineT;

    typedef logic [1:0] wayT;

    // bit 0 picks the half (0 means ways 0 and 1)
    // bit 1 picks within ways 0 and 1, bit 2 within ways 2 and 3
    typedef logic [2:0] plruT;

    typedef enum logic [1:0] {
        idle,
        waitResp,
        releaseHold
    } refillStateT;

    localparam int NumWays = 4;

    // byte offset inside one line
    localparam int OffsetBits = 4;

endpackage

// ==== wayStore.sv ====
`timescale 1ns/10ps

module wayStore #(
    parameter int SetBits = 6,
    localparam int TagBits = 32 - icachePkg::OffsetBits - SetBits
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [SetBits-1:0]   readIndex,
    input  logic                 writeEn,
    input  logic [SetBits-1:0]   writeIndex,
    input  logic [TagBits-1:0]   writeTag,
    input  icachePkg::lineT      writeLine,
    output logic [TagBits-1:0]   tagOut,
    output logic                 validOut,
    output icachePkg::lineT      lineOut
);
    import icachePkg::*;

    localparam int NumSets = 2 ** SetBits;

    logic [TagBits-1:0] tagMem [NumSets];
    lineT               lineMem [NumSets];
    logic [NumSets-1:0] validBits;

    // read returns the old contents when the same set is written on this edge
    always_ff @(posedge clk) begin
        if (writeEn) begin
            tagMem[writeIndex] <= writeTag;
            lineMem[writeIndex] <= writeLine;
        end
        tagOut <= tagMem[readIndex];
        lineOut <= lineMem[readIndex];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            validBits <= '0;
            validOut <= 1'b0;
        end else begin
            if (writeEn) begin
                validBits[writeIndex] <= 1'b1;
            end
            validOut <= validBits[readIndex];
        end
    end

endmodule

// ==== lookupStage.sv ====
`timescale 1ns/10ps

module lookupStage #(
    parameter int SetBits = 6,
    localparam int TagBits = 32 - icachePkg::OffsetBits - SetBits
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            reqValid,
    input  icachePkg::addrT                 reqPc,
    input  logic                            busy,
    input  logic [icachePkg::NumWays-1:0]   fillWe,
    input  icachePkg::addrT                 fillPc,
    input  icachePkg::lineT                 fillLine,
    output logic                            s1Valid,
    output icachePkg::addrT                 s1Pc,
    output logic [TagBits-1:0]              wayTags [icachePkg::NumWays],
    output logic [icachePkg::NumWays-1:0]   wayValids,
    output icachePkg::lineT                 wayLines [icachePkg::NumWays]
);
    import icachePkg::*;

    logic [SetBits-1:0] readIndex;
    logic [SetBits-1:0] fillIndex;
    logic [TagBits-1:0] fillTag;

    // a frozen request keeps re-reading its own set, so the fill shows up
    assign readIndex = busy ? s1Pc[OffsetBits +: SetBits] : reqPc[OffsetBits +: SetBits];
    assign fillIndex = fillPc[OffsetBits +: SetBits];
    assign fillTag = fillPc[31 -: TagBits];

    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
        end else if (!busy) begin
            s1Valid <= reqValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy) begin
            s1Pc <= reqPc;
        end
    end

    for (genvar w = 0; w < NumWays; w++) begin : genWay
        wayStore #(
            .SetBits(SetBits)
        ) wayStoreInst (
            .clk        (clk),
            .rst        (rst),
            .readIndex  (readIndex),
            .writeEn    (fillWe[w]),
            .writeIndex (fillIndex),
            .writeTag   (fillTag),
            .writeLine  (fillLine),
            .tagOut     (wayTags[w]),
            .validOut   (wayValids[w]),
            .lineOut    (wayLines[w])
        );
    end

endmodule

// ==== hitStage.sv ====
`timescale 1ns/10ps

module hitStage #(
    parameter int SetBits = 6,
    localparam int TagBits = 32 - icachePkg::OffsetBits - SetBits
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            s1Valid,
    input  icachePkg::addrT                 s1Pc,
    input  logic [TagBits-1:0]              wayTags [icachePkg::NumWays],
    input  logic [icachePkg::NumWays-1:0]   wayValids,
    input  icachePkg::lineT                 wayLines [icachePkg::NumWays],
    input  logic                            busy,
    input  logic                            memRespValid,
    input  icachePkg::lineT                 memRespLine,
    input  icachePkg::wayT                  fillWay,
    output logic                            respValid,
    output icachePkg::addrT                 respPc,
    output icachePkg::wordT                 inst0,
    output icachePkg::wordT                 inst1,
    output logic                            inst0Valid,
    output logic                            missValid,
    output icachePkg::addrT                 missPc,
    output icachePkg::wayT                  victimWay
);
    import icachePkg::*;

    localparam int NumSets = 2 ** SetBits;

    logic [SetBits-1:0] s1Set;
    logic [TagBits-1:0] s1Tag;
    logic [SetBits-1:0] missSet;
    logic [NumWays-1:0] hitVec;
    logic               takeHit;
    logic               takeMiss;
    logic               fillDone;
    wayT                hitWay;
    lineT               hitLine;
    wayT                victim;
    lineT               outLine;
    addrT               outPc;
    plruT               plru [NumSets];

    function automatic wordT pickWord(lineT line, logic [1:0] idx);
        return line[{idx, 5'b0} +: 32];
    endfunction

    // point the half bit and the pair bit away from the used way
    function automatic plruT touch(plruT bits, wayT way);
        plruT upd;
        upd = bits;
        upd[0] = ~way[1];
        if (way[1]) begin
            upd[2] = ~way[0];
        end else begin
            upd[1] = ~way[0];
        end
        return upd;
    endfunction

    assign s1Set = s1Pc[OffsetBits +: SetBits];
    assign s1Tag = s1Pc[31 -: TagBits];
    assign missSet = missPc[OffsetBits +: SetBits];

    always_comb begin
        hitWay = '0;
        hitLine = '0;
        for (int w = 0; w < NumWays; w++) begin
            hitVec[w] = wayValids[w] && (wayTags[w] == s1Tag);
            if (hitVec[w]) begin
                hitWay = wayT'(w);
                hitLine = wayLines[w];
            end
        end
    end

    // lowest empty way first, pseudo-LRU way once the set is full
    always_comb begin
        victim = plru[s1Set][0] ? {1'b1, plru[s1Set][2]} : {1'b0, plru[s1Set][1]};
        for (int w = NumWays - 1; w >= 0; w--) begin
            if (!wayValids[w]) begin
                victim = wayT'(w);
            end
        end
    end

    assign takeHit = s1Valid && !busy && (|hitVec);
    assign takeMiss = s1Valid && !busy && !(|hitVec);
    // the only response memory sends is the line of the held miss
    assign fillDone = busy && memRespValid;
    assign outLine = fillDone ? memRespLine : hitLine;
    assign outPc = fillDone ? missPc : s1Pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            respValid <= 1'b0;
            missValid <= 1'b0;
        end else begin
            respValid <= takeHit || fillDone;
            missValid <= takeMiss;
        end
    end

    always_ff @(posedge clk) begin
        if (takeHit || fillDone) begin
            respPc <= outPc;
            inst0 <= pickWord(outLine, {outPc[3], 1'b0});
            inst1 <= pickWord(outLine, {outPc[3], 1'b1});
            inst0Valid <= ~outPc[2];
        end
        if (takeMiss) begin
            missPc <= s1Pc;
            victimWay <= victim;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NumSets; s++) begin
                plru[s] <= '0;
            end
        end else if (takeHit) begin
            plru[s1Set] <= touch(plru[s1Set], hitWay);
        end else if (fillDone) begin
            plru[missSet] <= touch(plru[missSet], fillWay);
        end
    end

endmodule

// ==== refillCtrl.sv ====
`timescale 1ns/10ps

module refillCtrl #(
    parameter int SetBits = 6,
    localparam int TagBits = 32 - icachePkg::OffsetBits - SetBits
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            missValid,
    input  icachePkg::addrT                 missPc,
    input  icachePkg::wayT                  victimWay,
    input  logic                            memRespValid,
    input  icachePkg::lineT                 memRespLine,
    output logic                            memReqValid,
    output icachePkg::addrT                 memReqAddr,
    output logic                            busy,
    output logic [icachePkg::NumWays-1:0]   fillWe,
    output icachePkg::wayT                  fillWay,
    output icachePkg::addrT                 fillPc,
    output icachePkg::lineT                 fillLine
);
    import icachePkg::*;

    refillStateT        state;
    refillStateT        nextState;
    logic [TagBits-1:0] tagHold;
    logic [SetBits-1:0] setHold;
    wayT                wayHold;

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (missValid) begin
                    nextState = waitResp;
                end
            end
            waitResp: begin
                if (memRespValid) begin
                    nextState = releaseHold;
                end
            end
            // one extra busy cycle lets the frozen request see the new line
            releaseHold: begin
                nextState = idle;
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && missValid) begin
            tagHold <= missPc[31 -: TagBits];
            setHold <= missPc[OffsetBits +: SetBits];
            wayHold <= victimWay;
        end
    end

    // request goes out in the same cycle the miss strobe is seen
    assign memReqValid = (state == idle) && missValid;
    assign memReqAddr = {missPc[31:OffsetBits], {OffsetBits{1'b0}}};
    assign busy = missValid || (state != idle);

    assign fillWay = wayHold;
    assign fillPc = {tagHold, setHold, {OffsetBits{1'b0}}};
    assign fillLine = memRespLine;

    always_comb begin
        fillWe = '0;
        if (state == waitResp && memRespValid) begin
            fillWe[wayHold] = 1'b1;
        end
    end

endmodule

// ==== icacheTop.sv ====
`timescale 1ns/10ps

module icacheTop #(
    parameter int SetBits = 6
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            reqValid,
    input  icachePkg::addrT reqPc,
    output logic            respValid,
    output icachePkg::addrT respPc,
    output icachePkg::wordT inst0,
    output icachePkg::wordT inst1,
    output logic            inst0Valid,
    output logic            busy,
    output logic            memReqValid,
    output icachePkg::addrT memReqAddr,
    input  logic            memRespValid,
    input  icachePkg::lineT memRespLine
);
    import icachePkg::*;

    localparam int TagBits = 32 - OffsetBits - SetBits;

    logic               s1Valid;
    addrT               s1Pc;
    logic [TagBits-1:0] wayTags [NumWays];
    logic [NumWays-1:0] wayValids;
    lineT               wayLines [NumWays];
    logic               missValid;
    addrT               missPc;
    wayT                victimWay;
    logic [NumWays-1:0] fillWe;
    wayT                fillWay;
    addrT               fillPc;
    lineT               fillLine;

    lookupStage #(
        .SetBits(SetBits)
    ) lookupInst (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (reqValid),
        .reqPc     (reqPc),
        .busy      (busy),
        .fillWe    (fillWe),
        .fillPc    (fillPc),
        .fillLine  (fillLine),
        .s1Valid   (s1Valid),
        .s1Pc      (s1Pc),
        .wayTags   (wayTags),
        .wayValids (wayValids),
        .wayLines  (wayLines)
    );

    hitStage #(
        .SetBits(SetBits)
    ) hitInst (
        .clk          (clk),
        .rst          (rst),
        .s1Valid      (s1Valid),
        .s1Pc         (s1Pc),
        .wayTags      (wayTags),
        .wayValids    (wayValids),
        .wayLines     (wayLines),
        .busy         (busy),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .fillWay      (fillWay),
        .respValid    (respValid),
        .respPc       (respPc),
        .inst0        (inst0),
        .inst1        (inst1),
        .inst0Valid   (inst0Valid),
        .missValid    (missValid),
        .missPc       (missPc),
        .victimWay    (victimWay)
    );

    refillCtrl #(
        .SetBits(SetBits)
    ) refillInst (
        .clk          (clk),
        .rst          (rst),
        .missValid    (missValid),
        .missPc       (missPc),
        .victimWay    (victimWay),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .busy         (busy),
        .fillWe       (fillWe),
        .fillWay      (fillWay),
        .fillPc       (fillPc),
        .fillLine     (fillLine)
    );

endmodule

// ==== icacheTb_asserts.sv ====
`timescale 1ns/10ps

module icacheTbAsserts (
    input logic clk,
    input logic rst,
    input logic reqValid,
    input logic busy,
    input logic memReqValid,
    input logic memRespValid
);
    int failCount = 0;

    reqWhileBusy: assert property (@(posedge clk) disable iff (rst) !(reqValid && busy))
        else begin
            failCount++;
            $error("request sent while the cache is busy");
        end

    // a second miss may only start once the previous one has released busy
    memReqOverlap: assert property (@(posedge clk) disable iff (rst)
        memReqValid |-> !$past(busy))
        else begin
            failCount++;
            $error("memory request while a miss is outstanding");
        end

    memRespIdle: assert property (@(posedge clk) disable iff (rst) memRespValid |-> busy)
        else begin
            failCount++;
            $error("memory response while the cache is not busy");
        end

    busyRise: assert property (@(posedge clk) disable iff (rst) $rose(busy) |-> memReqValid)
        else begin
            failCount++;
            $error("busy rose without a memory request");
        end

endmodule

bind icacheTop icacheTbAsserts assertsInst (
    .clk          (clk),
    .rst          (rst),
    .reqValid     (reqValid),
    .busy         (busy),
    .memReqValid  (memReqValid),
    .memRespValid (memRespValid)
);

// ==== icacheTb.sv ====
`timescale 1ns/10ps

module icacheTb;
    import icachePkg::*;

    localparam int SetBits = 6;
    localparam int TagBits = 32 - OffsetBits - SetBits;
    localparam int NumSets = 2 ** SetBits;
    localparam int ClkPeriod = 100;
    localparam int RandomReqs = 300;
    localparam int TotalReqs = 7 + RandomReqs;
    localparam logic [TagBits-1:0] TagBase = 'h2b1;

    logic clk;
    logic rst;
    logic reqValid;
    addrT reqPc;
    logic respValid;
    addrT respPc;
    wordT inst0;
    wordT inst1;
    logic inst0Valid;
    logic busy;
    logic memReqValid;
    addrT memReqAddr;
    logic memRespValid;
    lineT memRespLine;

    logic [31:0]        lfsrState;
    int                 cycleCount = 0;
    logic [TagBits-1:0] modelTag [NumSets][NumWays];
    logic               modelValid [NumSets][NumWays];
    plruT               modelPlru [NumSets];
    addrT               expPc [$];
    string              expName [$];
    int                 expDue [$];
    addrT               expMemAddr [$];
    string              expMemName [$];
    logic               memPending;
    int                 memWait;
    addrT               memAddrHeld;
    logic               prevMiss;
    int                 hits;
    int                 misses;
    int                 evictions;
    int                 gap;

    icacheTop #(
        .SetBits(SetBits)
    ) dut_i (
        .clk          (clk),
        .rst          (rst),
        .reqValid     (reqValid),
        .reqPc        (reqPc),
        .respValid    (respValid),
        .respPc       (respPc),
        .inst0        (inst0),
        .inst1        (inst1),
        .inst0Valid   (inst0Valid),
        .busy         (busy),
        .memReqValid  (memReqValid),
        .memReqAddr   (memReqAddr),
        .memRespValid (memRespValid),
        .memRespLine  (memRespLine)
    );

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        #(TotalReqs * 15 * ClkPeriod);
        abortRun("watchdog timeout, the cache stopped answering");
    end

    task automatic abortRun(string why);
        $display("%s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkAddr(string name, addrT expected, addrT actual);
        if (actual !== expected) begin
            abortRun($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkWord(string name, wordT expected, wordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("Error: %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic checkBit(string name, logic expected, logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("Error: %s expected %b actual %b", name, expected, actual));
        end
    endtask

    // galois LFSR, one step per bit
    function automatic logic nextBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 32'h80200003;
        end
        return outBit;
    endfunction

    function automatic int takeBits(int n);
        int val;
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(nextBit());
        end
        return val;
    endfunction

    // odd multiplier keeps every address distinct
    function automatic wordT memWord(addrT a);
        return (a * 32'h9e3779b1) ^ 32'h5a0fc3e7;
    endfunction

    function automatic lineT lineAt(addrT base);
        lineT line;
        for (int i = 0; i < 4; i++) begin
            line[i*32 +: 32] = memWord(base + addrT'(i * 4));
        end
        return line;
    endfunction

    // a few tags crowd sets 5, 21 and 50, set 21 twice as often
    function automatic addrT poolAddr();
        logic [1:0]         setSel;
        logic [2:0]         tagSel;
        logic [1:0]         wordSel;
        logic [SetBits-1:0] setNum;
        logic [TagBits-1:0] tagVal;
        setSel = 2'(takeBits(2));
        tagSel = 3'(takeBits(3));
        wordSel = 2'(takeBits(2));
        case (setSel)
            2'd0: setNum = SetBits'(5);
            2'd3: setNum = SetBits'(50);
            default: setNum = SetBits'(21);
        endcase
        tagVal = TagBase + TagBits'(tagSel);
        return {tagVal, setNum, wordSel, 2'b00};
    endfunction

    function automatic wayT pickVictim(logic [SetBits-1:0] s);
        for (int w = 0; w < NumWays; w++) begin
            if (!modelValid[s][w]) begin
                return wayT'(w);
            end
        end
        // half bit set sends the victim to ways 2 and 3
        if (modelPlru[s][0]) begin
            return {1'b1, modelPlru[s][2]};
        end
        return {1'b0, modelPlru[s][1]};
    endfunction

    function automatic plruT markUsed(plruT bits, wayT way);
        plruT upd;
        upd = bits;
        if (way < 2'd2) begin
            upd[0] = 1'b1;
            upd[1] = (way == 2'd0);
        end else begin
            upd[0] = 1'b0;
            upd[2] = (way == 2'd2);
        end
        return upd;
    endfunction

    task automatic modelAccess(addrT pc, string name);
        logic [SetBits-1:0] s;
        logic [TagBits-1:0] t;
        int                 hitAt;
        int                 due;
        wayT                way;
        s = pc[OffsetBits +: SetBits];
        t = pc[31 -: TagBits];
        hitAt = -1;
        for (int w = 0; w < NumWays; w++) begin
            if (modelValid[s][w] && modelTag[s][w] == t) begin
                hitAt = w;
            end
        end
        // a request sampled while the previous miss is still unissued waits for the fill
        due = (prevMiss && expMemAddr.size() != 0) ? 0 : cycleCount + 2;
        if (hitAt >= 0) begin
            way = wayT'(hitAt);
            hits++;
        end else begin
            way = pickVictim(s);
            if (modelValid[s][way]) begin
                evictions++;
            end
            modelValid[s][way] = 1'b1;
            modelTag[s][way] = t;
            expMemAddr.push_back({pc[31:OffsetBits], {OffsetBits{1'b0}}});
            expMemName.push_back(name);
            due = 0;
            misses++;
        end
        modelPlru[s] = markUsed(modelPlru[s], way);
        expPc.push_back(pc);
        expName.push_back(name);
        expDue.push_back(due);
        prevMiss = (hitAt < 0);
    endtask

    task automatic checkResponse();
        string name;
        addrT  pc;
        int    due;
        if (expPc.size() == 0) begin
            abortRun("a response arrived with no request outstanding");
        end
        name = expName.pop_front();
        pc = expPc.pop_front();
        due = expDue.pop_front();
        checkAddr({name, " respPc"}, pc, respPc);
        checkWord({name, " inst0"}, memWord({pc[31:3], 3'b000}), inst0);
        checkWord({name, " inst1"}, memWord({pc[31:3], 3'b100}), inst1);
        checkBit({name, " inst0Valid"}, ~pc[2], inst0Valid);
        if (due != 0 && due != cycleCount) begin
            abortRun($sformatf("Error: %s hit latency expected cycle %0d actual cycle %0d",
                name, due, cycleCount));
        end
    endtask

    task automatic serviceMemory();
        string name;
        addrT  addr;
        if (memPending) begin
            memWait--;
            if (memWait == 0) begin
                memRespValid = 1'b1;
                memRespLine = lineAt(memAddrHeld);
                memPending = 1'b0;
            end
        end
        if (memReqValid) begin
            if (memPending || expMemAddr.size() == 0) begin
                abortRun("the cache sent a memory request where the model expected none");
            end
            name = expMemName.pop_front();
            addr = expMemAddr.pop_front();
            checkAddr({name, " memReqAddr"}, addr, memReqAddr);
            memAddrHeld = memReqAddr;
            memWait = 1 + takeBits(3);
            memPending = 1'b1;
        end
    endtask

    task automatic stepCycle();
        @(negedge clk);
        reqValid = 1'b0;
        memRespValid = 1'b0;
        if (dut_i.assertsInst.failCount != 0) begin
            abortRun("a protocol assertion failed");
        end
        if (respValid) begin
            checkResponse();
        end
        serviceMemory();
    endtask

    task automatic sendReq(addrT pc, string name);
        stepCycle();
        while (busy) begin
            stepCycle();
        end
        reqValid = 1'b1;
        reqPc = pc;
        modelAccess(pc, name);
    endtask

    initial begin
        lfsrState = 32'hf14ad867;
        rst = 1'b1;
        reqValid = 1'b0;
        reqPc = '0;
        memRespValid = 1'b0;
        memRespLine = '0;
        memPending = 1'b0;
        memWait = 0;
        memAddrHeld = '0;
        prevMiss = 1'b0;
        hits = 0;
        misses = 0;
        evictions = 0;
        for (int s = 0; s < NumSets; s++) begin
            modelPlru[s] = '0;
            for (int w = 0; w < NumWays; w++) begin
                modelValid[s][w] = 1'b0;
                modelTag[s][w] = '0;
            end
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        checkBit("reset busy", 1'b0, busy);
        checkBit("reset respValid", 1'b0, respValid);
        checkBit("reset memReqValid", 1'b0, memReqValid);

        sendReq(32'h0000_1004, "coldMiss");
        // second request is frozen behind the miss to its own line
        sendReq(32'h0000_2040, "frozenSameLine");
        sendReq(32'h0000_2048, "frozenSameLine");
        for (int i = 0; i < 4; i++) begin
            sendReq(32'h0000_2040 + addrT'(i * 4), "wordSelect");
        end

        for (int i = 0; i < RandomReqs; i++) begin
            if (takeBits(2) == 0) begin
                gap = takeBits(2);
                repeat (gap) stepCycle();
            end
            sendReq(poolAddr(), "randomMix");
        end

        while (expPc.size() != 0 || expMemAddr.size() != 0 || memPending) begin
            stepCycle();
        end
        repeat (5) stepCycle();
        if (evictions == 0) begin
            abortRun("the random requests never evicted a line");
        end
        $display("hits %0d misses %0d evictions %0d", hits, misses, evictions);
        if (dut_i.assertsInst.failCount == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abortRun("a protocol assertion failed");
        end
    end

endmodule

// ==== flist.f ====
icachePkg.sv
wayStore.sv
lookupStage.sv
hitStage.sv
refillCtrl.sv
icacheTop.sv
icacheTb_asserts.sv
icacheTb.sv

// ==== run.sh ====
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module icacheTb -f flist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/VicacheTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "ALL TESTS PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
